//--- arb_checker.sv
`timescale 1ns/1ns

module arb_checker
(
	input logic                CLK,
	input mem_arb_pkg::data_t  cpu_rdata,
	input logic                cpu_success,
	input logic                fl_wready,
	input mem_arb_pkg::data_t  spr_rdata,
	input logic                spr_rready,
	input mem_arb_pkg::data_t  bg_rdata,
	input logic                bg_rready,
	input logic                exp_cpu_success,
	input logic                exp_fl_wready,
	input logic                exp_spr_rready,
	input logic                exp_bg_rready,
	input mem_arb_pkg::data_t  exp_cpu_rdata,
	input mem_arb_pkg::data_t  exp_spr_rdata,
	input mem_arb_pkg::data_t  exp_bg_rdata,
	input mem_arb_pkg::mask_t  exp_cpu_known,
	input mem_arb_pkg::mask_t  exp_spr_known,
	input mem_arb_pkg::mask_t  exp_bg_known
);

	import mem_arb_pkg::*;

	int error_count = 0;
	int test_errors = 0; // errors inside the running test
	int tests_passed = 0;
	int tests_failed = 0;

	// bytes the model has seen written
	function automatic data_t lane_bits(input mask_t m);
		data_t bits;
		for (int i = 0; i < MASK_W; i++)
			bits[i*BYTE_W +: BYTE_W] = {BYTE_W{m[i]}};
		return bits;
	endfunction

	task automatic note_failure(input string msg);
		$display("%s", msg);
		error_count++;
		test_errors++;
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			note_failure($sformatf("FAIL %s expected %h got %h at %0t", name, exp, act, $time));
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act,
		input mask_t known);
		data_t lanes;
		lanes = lane_bits(known);
		if (((exp ^ act) & lanes) !== '0)
			note_failure($sformatf("FAIL %s expected %h got %h at %0t", name, exp & lanes,
				act & lanes, $time));
	endtask

	// outputs settle right after the edge, sample mid cycle
	always @(posedge CLK)
	begin
		#2;
		check_flag("cpu_success", exp_cpu_success, cpu_success);
		check_flag("fl_wready", exp_fl_wready, fl_wready);
		check_flag("spr_rready", exp_spr_rready, spr_rready);
		check_flag("bg_rready", exp_bg_rready, bg_rready);
		if (exp_cpu_success)
			check_data("cpu_rdata", exp_cpu_rdata, cpu_rdata, exp_cpu_known);
		if (exp_spr_rready)
			check_data("spr_rdata", exp_spr_rdata, spr_rdata, exp_spr_known);
		if (exp_bg_rready)
			check_data("bg_rdata", exp_bg_rdata, bg_rdata, exp_bg_known);
	end

	task automatic end_test(input string name);
		if (test_errors == 0)
		begin
			$display("test %s: passed", name);
			tests_passed++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	task automatic print_counts();
		$display("tests passed %0d, tests failed %0d, errors %0d", tests_passed,
			tests_failed, error_count);
	endtask

endmodule

//--- bank_arbiter.sv
`timescale 1ns/1ns

module bank_arbiter
#(
	parameter int BANK_AW = mem_arb_pkg::BANK_AW
)
(
	input  logic                    spr_valid,
	input  logic                    bg_valid,
	input  logic                    fl_valid,
	input  logic                    cpu_wr,
	input  mem_arb_pkg::addr_t      spr_addr,
	input  mem_arb_pkg::addr_t      bg_addr,
	input  mem_arb_pkg::addr_t      fl_addr,
	input  mem_arb_pkg::addr_t      cpu_addr,
	input  mem_arb_pkg::data_t      fl_wdata,
	input  mem_arb_pkg::data_t      cpu_wdata,
	input  mem_arb_pkg::mask_t      cpu_mask,
	output mem_arb_pkg::bank_sel_e  bank_sel,
	output mem_arb_pkg::bank_addr_t ram_addr,
	output mem_arb_pkg::data_t      ram_wdata,
	output logic                    ram_wr,
	output mem_arb_pkg::mask_t      ram_mask
);

	import mem_arb_pkg::*;

	// fixed priority with the cpu as fallback owner
	always_comb
	begin
		if (fl_valid)
			bank_sel = SEL_FLASH;
		else if (spr_valid)
			bank_sel = SEL_SPRITE;
		else if (bg_valid)
			bank_sel = SEL_BACKGROUND;
		else
			bank_sel = SEL_CPU;
	end

	// steer the owner onto the bank port
	always_comb
	begin
		ram_addr  = cpu_addr[BANK_AW-1:0];
		ram_wdata = cpu_wdata;
		ram_mask  = cpu_mask;
		ram_wr    = 1'b0;
		case (bank_sel)
			SEL_FLASH:
			begin
				ram_addr  = fl_addr[BANK_AW-1:0];
				ram_wdata = fl_wdata;
				ram_mask  = '1; // flash always writes whole words
				ram_wr    = 1'b1;
			end
			SEL_SPRITE:
			begin
				ram_addr = spr_addr[BANK_AW-1:0]; // read only
			end
			SEL_BACKGROUND:
			begin
				ram_addr = bg_addr[BANK_AW-1:0]; // read only
			end
			default:
			begin
				ram_wr = cpu_wr; // cpu write only lands while it owns the bank
			end
		endcase
	end

endmodule

//--- bank_ram.sv
`timescale 1ns/1ns

module bank_ram
#(
	parameter int BANK_AW = mem_arb_pkg::BANK_AW
)
(
	input  logic                    CLK,
	input  mem_arb_pkg::bank_addr_t ram_addr,
	input  mem_arb_pkg::data_t      ram_wdata,
	input  logic                    ram_wr,
	input  mem_arb_pkg::mask_t      ram_mask,
	output mem_arb_pkg::data_t      ram_rdata
);

	import mem_arb_pkg::*;

	localparam int DEPTH = 2 ** BANK_AW;

	data_t mem [DEPTH];

	// byte lanes written only where the mask is set
	always_ff @(posedge CLK)
	begin
		if (ram_wr)
		begin
			for (int i = 0; i < MASK_W; i++)
			begin
				if (ram_mask[i])
					mem[ram_addr][i*BYTE_W +: BYTE_W] <= ram_wdata[i*BYTE_W +: BYTE_W];
			end
		end
	end

	// registered read, old word on a same-address write
	always_ff @(posedge CLK)
	begin
		ram_rdata <= mem[ram_addr];
	end

endmodule

//--- mem_arb_pkg.sv
package mem_arb_pkg;

	localparam int ADDR_W     = 16;
	localparam int DATA_W     = 16;
	localparam int BANK_COUNT = 4;
	localparam int BANK_AW    = 14;
	localparam int BYTE_W     = 8;
	localparam int MASK_W     = DATA_W / BYTE_W; // one enable per byte lane
	localparam int BANK_IDX_W = $clog2(BANK_COUNT);

	typedef logic [ADDR_W-1:0]     addr_t;      // full requester address
	typedef logic [DATA_W-1:0]     data_t;      // memory word
	typedef logic [BANK_AW-1:0]    bank_addr_t; // word address inside a bank
	typedef logic [BANK_IDX_W-1:0] bank_idx_t;  // bank number from the top address bits
	typedef logic [MASK_W-1:0]     mask_t;      // bit 1 is the high byte

	// owner of a bank in the current cycle
	typedef enum logic [1:0]
	{
		SEL_CPU        = 2'd0,
		SEL_FLASH      = 2'd1,
		SEL_BACKGROUND = 2'd2,
		SEL_SPRITE     = 2'd3
	} bank_sel_e;

	// bank 0 holds program code, video fetchers stay out
	localparam logic [BANK_COUNT-1:0] VIDEO_BANK_MASK = {{(BANK_COUNT-1){1'b1}}, 1'b0};

endpackage

//--- memory_arbiter.sv
`timescale 1ns/1ns

module memory_arbiter
#(
	parameter int BANK_COUNT = mem_arb_pkg::BANK_COUNT,
	parameter int BANK_AW    = mem_arb_pkg::BANK_AW
)
(
	input  logic               CLK,
	input  logic               rst_n,

	input  mem_arb_pkg::addr_t cpu_addr,
	input  mem_arb_pkg::data_t cpu_wdata,
	input  logic               cpu_wr,
	input  mem_arb_pkg::mask_t cpu_mask,
	output mem_arb_pkg::data_t cpu_rdata,
	output logic               cpu_success, // low means reissue

	input  mem_arb_pkg::addr_t fl_addr,
	input  mem_arb_pkg::data_t fl_wdata,
	input  logic               fl_wvalid,
	output logic               fl_wready,

	input  mem_arb_pkg::addr_t spr_addr,
	input  logic               spr_rvalid,
	output mem_arb_pkg::data_t spr_rdata,
	output logic               spr_rready,

	input  mem_arb_pkg::addr_t bg_addr,
	input  logic               bg_rvalid,
	output mem_arb_pkg::data_t bg_rdata,
	output logic               bg_rready
);

	import mem_arb_pkg::*;

	logic [BANK_COUNT-1:0] spr_bank_valid;
	logic [BANK_COUNT-1:0] bg_bank_valid;
	logic [BANK_COUNT-1:0] fl_bank_valid;
	logic [BANK_COUNT-1:0] cpu_bank_wr;
	bank_idx_t             cpu_bank;

	bank_sel_e  bank_sel [BANK_COUNT];
	bank_addr_t ram_addr [BANK_COUNT];
	data_t      ram_wdata [BANK_COUNT];
	logic       ram_wr [BANK_COUNT];
	mask_t      ram_mask [BANK_COUNT];
	data_t      ram_rdata [BANK_COUNT];

	request_decoder #(
		.BANK_COUNT (BANK_COUNT),
		.BANK_AW    (BANK_AW)
	) u_decoder (
		.spr_addr       (spr_addr),
		.bg_addr        (bg_addr),
		.fl_addr        (fl_addr),
		.cpu_addr       (cpu_addr),
		.spr_rvalid     (spr_rvalid),
		.bg_rvalid      (bg_rvalid),
		.fl_wvalid      (fl_wvalid),
		.cpu_wr         (cpu_wr),
		.spr_bank_valid (spr_bank_valid),
		.bg_bank_valid  (bg_bank_valid),
		.fl_bank_valid  (fl_bank_valid),
		.cpu_bank_wr    (cpu_bank_wr),
		.cpu_bank       (cpu_bank)
	);

	// one arbiter and one ram per bank, banks run in parallel
	for (genvar b = 0; b < BANK_COUNT; b++)
	begin : g_bank
		bank_arbiter #(
			.BANK_AW (BANK_AW)
		) u_arb (
			.spr_valid (spr_bank_valid[b]),
			.bg_valid  (bg_bank_valid[b]),
			.fl_valid  (fl_bank_valid[b]),
			.cpu_wr    (cpu_bank_wr[b]),
			.spr_addr  (spr_addr),
			.bg_addr   (bg_addr),
			.fl_addr   (fl_addr),
			.cpu_addr  (cpu_addr),
			.fl_wdata  (fl_wdata),
			.cpu_wdata (cpu_wdata),
			.cpu_mask  (cpu_mask),
			.bank_sel  (bank_sel[b]),
			.ram_addr  (ram_addr[b]),
			.ram_wdata (ram_wdata[b]),
			.ram_wr    (ram_wr[b]),
			.ram_mask  (ram_mask[b])
		);

		bank_ram #(
			.BANK_AW (BANK_AW)
		) u_ram (
			.CLK       (CLK),
			.ram_addr  (ram_addr[b]),
			.ram_wdata (ram_wdata[b]),
			.ram_wr    (ram_wr[b]),
			.ram_mask  (ram_mask[b]),
			.ram_rdata (ram_rdata[b])
		);
	end

	response_router #(
		.BANK_COUNT (BANK_COUNT),
		.BANK_AW    (BANK_AW)
	) u_router (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.bank_sel    (bank_sel),
		.ram_rdata   (ram_rdata),
		.cpu_bank    (cpu_bank),
		.spr_addr    (spr_addr),
		.bg_addr     (bg_addr),
		.cpu_rdata   (cpu_rdata),
		.spr_rdata   (spr_rdata),
		.bg_rdata    (bg_rdata),
		.cpu_success (cpu_success),
		.fl_wready   (fl_wready),
		.spr_rready  (spr_rready),
		.bg_rready   (bg_rready)
	);

endmodule

//--- request_decoder.sv
`timescale 1ns/1ns

module request_decoder
#(
	parameter int BANK_COUNT = mem_arb_pkg::BANK_COUNT,
	parameter int BANK_AW    = mem_arb_pkg::BANK_AW
)
(
	input  mem_arb_pkg::addr_t     spr_addr,
	input  mem_arb_pkg::addr_t     bg_addr,
	input  mem_arb_pkg::addr_t     fl_addr,
	input  mem_arb_pkg::addr_t     cpu_addr,
	input  logic                   spr_rvalid,
	input  logic                   bg_rvalid,
	input  logic                   fl_wvalid,
	input  logic                   cpu_wr,
	output logic [BANK_COUNT-1:0]  spr_bank_valid,
	output logic [BANK_COUNT-1:0]  bg_bank_valid,
	output logic [BANK_COUNT-1:0]  fl_bank_valid,
	output logic [BANK_COUNT-1:0]  cpu_bank_wr,
	output mem_arb_pkg::bank_idx_t cpu_bank
);

	import mem_arb_pkg::*;

	localparam int BANK_BITS = ADDR_W - BANK_AW; // top address bits that pick the bank

	logic [BANK_BITS-1:0]  spr_bank;
	logic [BANK_BITS-1:0]  bg_bank;
	logic [BANK_BITS-1:0]  fl_bank;
	logic [BANK_BITS-1:0]  cpu_bank_bits;
	logic [BANK_COUNT-1:0] spr_hit;
	logic [BANK_COUNT-1:0] bg_hit;

	assign spr_bank      = spr_addr[ADDR_W-1 -: BANK_BITS];
	assign bg_bank       = bg_addr[ADDR_W-1 -: BANK_BITS];
	assign fl_bank       = fl_addr[ADDR_W-1 -: BANK_BITS];
	assign cpu_bank_bits = cpu_addr[ADDR_W-1 -: BANK_BITS];

	// one-hot valid per bank for every requester
	for (genvar b = 0; b < BANK_COUNT; b++)
	begin : g_dec
		assign spr_hit[b]       = spr_rvalid && (spr_bank == BANK_BITS'(b));
		assign bg_hit[b]        = bg_rvalid && (bg_bank == BANK_BITS'(b));
		assign fl_bank_valid[b] = fl_wvalid && (fl_bank == BANK_BITS'(b)); // flash reaches every bank
		assign cpu_bank_wr[b]   = cpu_wr && (cpu_bank_bits == BANK_BITS'(b));
	end

	// a video read aimed at bank 0 never reaches an arbiter
	assign spr_bank_valid = spr_hit & VIDEO_BANK_MASK;
	assign bg_bank_valid  = bg_hit & VIDEO_BANK_MASK;

	assign cpu_bank = bank_idx_t'(cpu_bank_bits); // router steers cpu data with this

endmodule

//--- response_router.sv
`timescale 1ns/1ns

module response_router
#(
	parameter int BANK_COUNT = mem_arb_pkg::BANK_COUNT,
	parameter int BANK_AW    = mem_arb_pkg::BANK_AW
)
(
	input  logic                   CLK,
	input  logic                   rst_n,
	input  mem_arb_pkg::bank_sel_e bank_sel [BANK_COUNT],
	input  mem_arb_pkg::data_t     ram_rdata [BANK_COUNT],
	input  mem_arb_pkg::bank_idx_t cpu_bank,
	input  mem_arb_pkg::addr_t     spr_addr,
	input  mem_arb_pkg::addr_t     bg_addr,
	output mem_arb_pkg::data_t     cpu_rdata,
	output mem_arb_pkg::data_t     spr_rdata,
	output mem_arb_pkg::data_t     bg_rdata,
	output logic                   cpu_success,
	output logic                   fl_wready,
	output logic                   spr_rready,
	output logic                   bg_rready
);

	import mem_arb_pkg::*;

	localparam int BANK_BITS = ADDR_W - BANK_AW;

	bank_sel_e sel_q [BANK_COUNT]; // owner of each bank last cycle
	logic      cpu_hit_q;          // cpu owned its own bank last cycle
	bank_idx_t cpu_bank_q;
	bank_idx_t spr_bank_q;
	bank_idx_t bg_bank_q;

	always_ff @(posedge CLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int b = 0; b < BANK_COUNT; b++)
				sel_q[b] <= SEL_CPU;
			cpu_hit_q <= 1'b0;
		end
		else
		begin
			for (int b = 0; b < BANK_COUNT; b++)
				sel_q[b] <= bank_sel[b];
			cpu_hit_q <= (bank_sel[cpu_bank] == SEL_CPU);
		end
	end

	// bank numbers only steer read data
	always_ff @(posedge CLK)
	begin
		cpu_bank_q <= cpu_bank;
		spr_bank_q <= bank_idx_t'(spr_addr[ADDR_W-1 -: BANK_BITS]);
		bg_bank_q  <= bank_idx_t'(bg_addr[ADDR_W-1 -: BANK_BITS]);
	end

	// ready when any bank served the requester last cycle
	always_comb
	begin
		fl_wready  = 1'b0;
		spr_rready = 1'b0;
		bg_rready  = 1'b0;
		for (int b = 0; b < BANK_COUNT; b++)
		begin
			if (sel_q[b] == SEL_FLASH)
				fl_wready = 1'b1;
			if (sel_q[b] == SEL_SPRITE)
				spr_rready = 1'b1;
			if (sel_q[b] == SEL_BACKGROUND)
				bg_rready = 1'b1;
		end
	end

	assign cpu_success = cpu_hit_q;

	// read data from the bank each requester addressed
	assign cpu_rdata = ram_rdata[cpu_bank_q];
	assign spr_rdata = ram_rdata[spr_bank_q];
	assign bg_rdata  = ram_rdata[bg_bank_q];

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the memory arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_memory_arbiter -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "compile step failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1

//--- sim.f
mem_arb_pkg.sv
request_decoder.sv
bank_arbiter.sv
bank_ram.sv
response_router.sv
memory_arbiter.sv
arb_checker.sv
tb_memory_arbiter.sv

//--- tb_memory_arbiter.sv
`timescale 1ns/1ns

module tb_memory_arbiter;

	import mem_arb_pkg::*;

	logic  CLK;
	logic  rst_n;
	addr_t cpu_addr;
	data_t cpu_wdata;
	logic  cpu_wr;
	mask_t cpu_mask;
	data_t cpu_rdata;
	logic  cpu_success;
	addr_t fl_addr;
	data_t fl_wdata;
	logic  fl_wvalid;
	logic  fl_wready;
	addr_t spr_addr;
	logic  spr_rvalid;
	data_t spr_rdata;
	logic  spr_rready;
	addr_t bg_addr;
	logic  bg_rvalid;
	data_t bg_rdata;
	logic  bg_rready;

	logic  exp_cpu_success = 0;
	logic  exp_fl_wready = 0;
	logic  exp_spr_rready = 0;
	logic  exp_bg_rready = 0;
	data_t exp_cpu_rdata = '0;
	data_t exp_spr_rdata = '0;
	data_t exp_bg_rdata = '0;
	mask_t exp_cpu_known = '0;
	mask_t exp_spr_known = '0;
	mask_t exp_bg_known = '0;

	data_t shadow [65536];
	mask_t known [65536]; // bytes written so far

	int seed = 32'h4ad61e36;

	memory_arbiter #(.BANK_COUNT(BANK_COUNT), .BANK_AW(BANK_AW)) DUT (.*);

	arb_checker chk (.*);

	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// reference model runs late in the cycle on stable inputs
	task automatic model_step();
		bank_idx_t fb;
		bank_idx_t sb;
		bank_idx_t gb;
		bank_idx_t cb;
		logic      spr_req;
		logic      bg_req;
		fb = fl_addr[15:14];
		sb = spr_addr[15:14];
		gb = bg_addr[15:14];
		cb = cpu_addr[15:14];
		spr_req = spr_rvalid && (sb != 2'd0); // bank 0 is program memory
		bg_req = bg_rvalid && (gb != 2'd0);
		if (!rst_n)
		begin
			exp_fl_wready = 0;
			exp_spr_rready = 0;
			exp_bg_rready = 0;
			exp_cpu_success = 0;
		end
		else
		begin
			exp_fl_wready = fl_wvalid;
			exp_spr_rready = spr_req && !(fl_wvalid && fb == sb);
			exp_bg_rready = bg_req && !(fl_wvalid && fb == gb) && !(spr_req && sb == gb);
			exp_cpu_success = !(fl_wvalid && fb == cb) && !(spr_req && sb == cb)
				&& !(bg_req && gb == cb);
			exp_cpu_rdata = shadow[cpu_addr];
			exp_cpu_known = known[cpu_addr];
			exp_spr_rdata = shadow[spr_addr];
			exp_spr_known = known[spr_addr];
			exp_bg_rdata = shadow[bg_addr];
			exp_bg_known = known[bg_addr];
			if (fl_wvalid)
			begin
				shadow[fl_addr] = fl_wdata;
				known[fl_addr] = 2'b11;
			end
			if (exp_cpu_success && cpu_wr)
			begin
				if (cpu_mask[0])
					shadow[cpu_addr][7:0] = cpu_wdata[7:0];
				if (cpu_mask[1])
					shadow[cpu_addr][15:8] = cpu_wdata[15:8];
				known[cpu_addr] = known[cpu_addr] | cpu_mask;
			end
		end
	endtask

	always @(posedge CLK)
	begin
		#3;
		model_step();
	end

	task automatic flash_write(input addr_t a, input data_t d);
		int n = 0;
		fl_addr = a;
		fl_wdata = d;
		fl_wvalid = 1'b1;
		do
		begin
			@(posedge CLK);
			#1;
			n++;
		end while (!fl_wready && n < 20);
		if (!fl_wready)
			chk.note_failure($sformatf("flash write to %h was never accepted", a));
		fl_wvalid = 1'b0;
	endtask

	task automatic cpu_access(input addr_t a, input data_t d, input logic wr, input mask_t m);
		int n = 0;
		cpu_addr = a;
		cpu_wdata = d;
		cpu_wr = wr;
		cpu_mask = m;
		do
		begin
			@(posedge CLK);
			#1;
			n++;
		end while (!cpu_success && n < 20);
		if (!cpu_success)
			chk.note_failure($sformatf("cpu access to %h never succeeded", a));
		cpu_wr = 1'b0;
	endtask

	task automatic video_read(input logic is_bg, input addr_t a, input int limit,
		output logic served);
		int n = 0;
		if (is_bg)
		begin
			bg_addr = a;
			bg_rvalid = 1'b1;
		end
		else
		begin
			spr_addr = a;
			spr_rvalid = 1'b1;
		end
		do
		begin
			@(posedge CLK);
			#1;
			n++;
			served = is_bg ? bg_rready : spr_rready;
		end while (!served && n < limit);
		if (is_bg)
			bg_rvalid = 1'b0;
		else
			spr_rvalid = 1'b0;
	endtask

	task automatic random_traffic(input int cycles);
		logic [31:0] r;
		int          fl_wait = 0;
		int          spr_wait = 0;
		int          bg_wait = 0;
		for (int c = 0; c < cycles; c++)
		begin
			@(posedge CLK);
			#1;
			r = $random(seed);
			cpu_addr = {r[1:0], 10'h000, r[5:2]};
			cpu_wdata = r[21:6];
			cpu_wr = r[22] & r[23];
			cpu_mask = r[25:24];
			r = $random(seed);
			if (fl_wvalid)
			begin
				fl_wait++;
				if (fl_wready || fl_wait > 30)
				begin
					if (!fl_wready)
						chk.note_failure("flash request timed out in mixed traffic");
					fl_wvalid = 1'b0;
				end
			end
			else if (r[0] & r[1])
			begin
				fl_addr = {r[3:2], 10'h000, r[7:4]};
				fl_wdata = r[23:8];
				fl_wvalid = 1'b1;
				fl_wait = 0;
			end
			r = $random(seed);
			if (spr_rvalid)
			begin
				spr_wait++;
				if (spr_rready || spr_wait > 30)
				begin
					if (!spr_rready)
						chk.note_failure("sprite request timed out in mixed traffic");
					spr_rvalid = 1'b0;
				end
			end
			else if (r[0])
			begin
				spr_addr = {(r[2:1] == 2'd0) ? 2'd1 : r[2:1], 10'h000, r[6:3]};
				spr_rvalid = 1'b1;
				spr_wait = 0;
			end
			if (bg_rvalid)
			begin
				bg_wait++;
				if (bg_rready || bg_wait > 30)
				begin
					if (!bg_rready)
						chk.note_failure("background request timed out in mixed traffic");
					bg_rvalid = 1'b0;
				end
			end
			else if (r[8])
			begin
				bg_addr = {(r[10:9] == 2'd0) ? 2'd3 : r[10:9], 10'h000, r[14:11]};
				bg_rvalid = 1'b1;
				bg_wait = 0;
			end
		end
		@(posedge CLK);
		#1;
		fl_wvalid = 1'b0;
		spr_rvalid = 1'b0;
		bg_rvalid = 1'b0;
		cpu_wr = 1'b0;
	endtask

	// one more cycle so the checker scores the last response of the test
	task automatic close_test(input string name);
		@(posedge CLK);
		#1;
		chk.end_test(name);
	endtask

	initial
	begin
		addr_t       addrs [8];
		logic [31:0] r;
		logic        s1;
		logic        s2;
		for (int i = 0; i < 65536; i++)
			known[i] = '0;
		rst_n = 1'b0;
		{cpu_addr, cpu_wdata, cpu_wr, cpu_mask} = '0;
		{fl_addr, fl_wdata, fl_wvalid} = '0;
		{spr_addr, spr_rvalid, bg_addr, bg_rvalid} = '0;
		repeat (3) @(posedge CLK);
		#1;
		if (cpu_success || fl_wready || spr_rready || bg_rready)
			chk.note_failure("a ready flag was high during reset");
		rst_n = 1'b1;
		close_test("reset state");

		for (int i = 0; i < 8; i++)
		begin
			r = $random(seed);
			addrs[i] = {2'(i % 4), r[13:0]};
			flash_write(addrs[i], r[29:14]);
		end
		for (int i = 0; i < 8; i++)
			cpu_access(addrs[i], '0, 1'b0, 2'b00);
		close_test("flash then cpu");

		cpu_access(16'h4321, 16'h1234, 1'b1, 2'b11);
		cpu_access(16'h4321, 16'hffab, 1'b1, 2'b01);
		cpu_access(16'h4321, '0, 1'b0, 2'b00);
		cpu_access(16'h4321, 16'hcdff, 1'b1, 2'b10);
		cpu_access(16'h4321, '0, 1'b0, 2'b00);
		close_test("byte masks");

		// all four hit bank 2 at once
		fork
			flash_write(16'h8010, 16'h5a5a);
			video_read(1'b0, 16'h8020, 20, s1);
			video_read(1'b1, 16'h8030, 20, s2);
			cpu_access(16'h8040, '0, 1'b0, 2'b00);
		join
		if (!s1 || !s2)
			chk.note_failure("a video reader lost bank 2 for good");
		close_test("same-bank contention");

		flash_write(16'h0100, 16'h0bad);
		fork
			video_read(1'b0, 16'h0100, 20, s1);
			video_read(1'b1, 16'h0100, 20, s2);
		join
		if (s1 || s2)
			chk.note_failure("a video read of bank 0 was granted");
		cpu_access(16'h0100, '0, 1'b0, 2'b00);
		close_test("bank 0 block");

		random_traffic(2000);
		close_test("random mixed traffic");

		chk.print_counts();
		if (chk.error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// last line of defense against a stuck run
	initial
	begin
		for (int i = 0; i < 20000; i++)
			@(posedge CLK);
		$display("simulation ran past its cycle limit");
		$display("Test failed");
		$finish;
	end

endmodule
